/* verilog/mem_pkg.sv */
//////////////////////////////////////////////////////////////////////
// tagged memory bus, 16-bit byte address and 64-bit blocks
// response tag zero means the command was refused
//////////////////////////////////////////////////////////////////////
package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus widths
	//////////////////////////////////////////////////////////////////////

	// byte address
	localparam int MEM_ADDR_BITS = 16;
	// one block per transfer
	localparam int MEM_DATA_BITS = 64;
	// response / data tag, zero reserved
	localparam int MEM_TAG_BITS = 4;

	// bus command, only NONE and LOAD are driven here
	typedef enum logic [1:0] {
		NONE  = 2'b00,
		LOAD  = 2'b01,
		STORE = 2'b10
	} mem_cmd_t;

	// command and address, 18 bits
	typedef struct packed {
		mem_cmd_t                 cmd;
		logic [MEM_ADDR_BITS-1:0] addr;
	} mem_req_t;

endpackage

/* verilog/cache_pkg.sv */
//////////////////////////////////////////////////////////////////////
// direct-mapped icache geometry, tag + index + offset span the address
//////////////////////////////////////////////////////////////////////
package cache_pkg;
	import mem_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// geometry
	//////////////////////////////////////////////////////////////////////

	// fetch ways served in parallel
	localparam int WAYS = 2;
	// 32 lines
	localparam int INDEX_BITS = 5;
	localparam int TAG_BITS = 8;
	// byte within the 64-bit block
	localparam int OFFSET_BITS = 3;
	localparam int LINES = 1 << INDEX_BITS;

	// fetch way request, 17 bits
	typedef struct packed {
		logic                     en;
		logic [MEM_ADDR_BITS-1:0] addr;
	} fetch_req_t;

	// block back to the fetch way, 65 bits
	typedef struct packed {
		logic                     valid;
		logic [MEM_DATA_BITS-1:0] data;
	} fetch_rsp_t;

	// one-cycle line write, 78 bits
	typedef struct packed {
		logic                     strobe;
		logic [INDEX_BITS-1:0]    index;
		logic [TAG_BITS-1:0]      tag;
		logic [MEM_DATA_BITS-1:0] data;
	} refill_t;

endpackage

/* verilog/cache_mem.sv */
//////////////////////////////////////////////////////////////////////
// combinational lookup per way, refill lands on the edge after strobe
//////////////////////////////////////////////////////////////////////
module cache_mem
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic                  clock,
	input  logic                  arst_n,
	input  fetch_req_t [WAYS-1:0] fetch_req,
	input  refill_t               refill,
	output fetch_rsp_t [WAYS-1:0] fetch_rsp,
	output logic       [WAYS-1:0] miss
);

	//////////////////////////////////////////////////////////////////////
	// line storage
	//////////////////////////////////////////////////////////////////////

	// block data and stored tags
	logic [MEM_DATA_BITS-1:0] data_q [LINES];
	logic [TAG_BITS-1:0]      tag_q  [LINES];
	// one valid bit per line
	logic [LINES-1:0]         valid_q;

	// payload write, single port
	always_ff @(posedge clock) begin
		if (refill.strobe) begin
			data_q[refill.index] <= refill.data;
			tag_q[refill.index]  <= refill.tag;
		end
	end

	// valid bits, all lines empty out of reset
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (refill.strobe) begin
			valid_q[refill.index] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// per-way lookup
	//////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		logic [INDEX_BITS-1:0] idx;
		logic [TAG_BITS-1:0]   tag;
		logic                  hit;

		// split the fetch address, offset bits ignored
		assign idx = fetch_req[w].addr[OFFSET_BITS +: INDEX_BITS];
		assign tag = fetch_req[w].addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];

		// line present and tags agree
		assign hit = valid_q[idx] && (tag_q[idx] == tag);

		// only an enabled way can hit or miss
		assign fetch_rsp[w].valid = fetch_req[w].en && hit;
		assign fetch_rsp[w].data  = data_q[idx];
		assign miss[w]            = fetch_req[w].en && !hit;

		// a refilled line answers its way on the next cycle
		a_refill_hit: assert property (
			@(posedge clock) disable iff (!arst_n)
			refill.strobe && fetch_req[w].en && refill.index == idx && refill.tag == tag
			|=> fetch_rsp[w].valid || !fetch_req[w].en || !$stable(idx) || !$stable(tag)
		);
	end

endmodule

/* verilog/icache_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// one miss outstanding, lowest missing way first
// tag zero is never a pending tag, so an idle bus cannot match
//////////////////////////////////////////////////////////////////////
module icache_ctrl
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  fetch_req_t [WAYS-1:0]    fetch_req,
	input  logic [WAYS-1:0]          miss,
	input  logic [MEM_TAG_BITS-1:0]  mem_response,
	input  logic [MEM_TAG_BITS-1:0]  mem_tag,
	input  logic [MEM_DATA_BITS-1:0] mem_data,
	output mem_req_t                 mem_req,
	output refill_t                  refill
);

	// idle, LOAD on the bus, waiting for the data tag
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t                   state_q;
	state_t                   state_d;
	// block-aligned address of the miss in flight
	logic [MEM_ADDR_BITS-1:0] pend_addr_q;
	// tag handed back when memory took the LOAD
	logic [MEM_TAG_BITS-1:0]  pend_tag_q;
	// address of the lowest missing way
	logic [MEM_ADDR_BITS-1:0] sel_addr;
	logic                     accepted;
	logic                     tag_match;

	//////////////////////////////////////////////////////////////////////
	// miss selection
	//////////////////////////////////////////////////////////////////////

	// walk down so way 0 wins
	always_comb begin : pick_way
		sel_addr = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (miss[w]) begin
				sel_addr = fetch_req[w].addr;
			end
		end
	end

	// latch on leaving idle, offset bits dropped
	always_ff @(posedge clock) begin
		if (state_q == ST_IDLE && |miss) begin
			pend_addr_q <= {sel_addr[MEM_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	// nonzero response takes the LOAD
	assign accepted  = (state_q == ST_REQ) && (mem_response != '0);
	// returning data for our request
	assign tag_match = (state_q == ST_WAIT) && (mem_tag == pend_tag_q);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (|miss) begin
					state_d = ST_REQ;
				end
			end
			// refused LOADs just stay here and go out again
			ST_REQ: begin
				if (accepted) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (tag_match) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= ST_IDLE;
			pend_tag_q <= '0;
		end else begin
			state_q <= state_d;
			if (accepted) begin
				pend_tag_q <= mem_response;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////////////////////////

	// LOAD held until a nonzero response
	assign mem_req.cmd  = (state_q == ST_REQ) ? LOAD : NONE;
	assign mem_req.addr = (state_q == ST_REQ) ? pend_addr_q : '0;

	// strobe carries this cycle's bus data
	assign refill.strobe = tag_match;
	assign refill.index  = pend_addr_q[OFFSET_BITS +: INDEX_BITS];
	assign refill.tag    = pend_addr_q[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign refill.data   = mem_data;

	// stores never leave the fetch path
	a_no_store: assert property (
		@(posedge clock) disable iff (!arst_n)
		mem_req.cmd != STORE
	);

	// strobe only while waiting, and only on a real data beat
	a_strobe_wait: assert property (
		@(posedge clock) disable iff (!arst_n)
		refill.strobe |-> (state_q == ST_WAIT) && (mem_tag != '0)
	);

endmodule

/* verilog/fetch_cache.sv */
//////////////////////////////////////////////////////////////////////
// icache top, hits are combinational, stores are never issued
//////////////////////////////////////////////////////////////////////
module fetch_cache
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  fetch_req_t [WAYS-1:0]    fetch_req,
	input  logic [MEM_TAG_BITS-1:0]  mem_response,
	input  logic [MEM_TAG_BITS-1:0]  mem_tag,
	input  logic [MEM_DATA_BITS-1:0] mem_data,
	output fetch_rsp_t [WAYS-1:0]    fetch_rsp,
	output mem_req_t                 mem_req
);

	// controller to storage
	refill_t         refill;
	// storage to controller
	logic [WAYS-1:0] miss;

	// lines, tags and lookup
	cache_mem u_cache_mem (
		.clock     (clock),
		.arst_n    (arst_n),
		.fetch_req (fetch_req),
		.refill    (refill),
		.fetch_rsp (fetch_rsp),
		.miss      (miss)
	);

	// miss handling and bus side
	icache_ctrl u_icache_ctrl (
		.clock        (clock),
		.arst_n       (arst_n),
		.fetch_req    (fetch_req),
		.miss         (miss),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data),
		.mem_req      (mem_req),
		.refill       (refill)
	);

endmodule

/* bench/mem_model.sv */
//////////////////////////////////////////////////////////////////////
// tagged memory responder, refusal chance given in percent
//////////////////////////////////////////////////////////////////////
module mem_model
	import mem_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  mem_req_t                 mem_req,
	// percent of LOADs answered with tag zero
	input  int                       refuse_pct,
	output logic [MEM_TAG_BITS-1:0]  mem_response,
	output logic [MEM_TAG_BITS-1:0]  mem_tag,
	// block address of the beat now on mem_tag
	output logic [MEM_ADDR_BITS-1:0] ret_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// accepted LOAD waiting for its data beat
	typedef struct packed {
		logic [MEM_TAG_BITS-1:0]  tag;
		logic [MEM_ADDR_BITS-1:0] addr;
		int unsigned              due;
	} pend_t;

	int                       seed = 31;
	int unsigned              now = 0;
	logic [MEM_TAG_BITS-1:0]  next_tag = MEM_TAG_BITS'(1);
	logic [MEM_TAG_BITS-1:0]  resp_q = '0;
	logic [MEM_TAG_BITS-1:0]  tag_q = '0;
	logic [MEM_ADDR_BITS-1:0] addr_q = '0;
	pend_t                    pend_q [$];

	assign mem_response = resp_q;
	assign mem_tag      = tag_q;
	assign ret_addr     = addr_q;

	// all bus outputs change on the falling edge
	always @(negedge clock) begin : respond
		pend_t p;
		resp_q = '0;
		tag_q  = '0;
		if (!arst_n) begin
			pend_q.delete();
		end else begin
			now = now + 1;
			// oldest beat first, at most one per cycle
			if (pend_q.size() > 0 && pend_q[0].due <= now) begin
				p      = pend_q.pop_front();
				tag_q  = p.tag;
				addr_q = p.addr;
			end
			// answer the LOAD on the bus, the DUT takes it on the next edge
			if (mem_req.cmd == LOAD && {$random(seed)} % 100 >= refuse_pct) begin
				resp_q = next_tag;
				p.tag  = next_tag;
				p.addr = mem_req.addr;
				// data 2 to 8 cycles later
				p.due  = now + 2 + {$random(seed)} % 7;
				pend_q.push_back(p);
				next_tag = (next_tag == '1) ? MEM_TAG_BITS'(1) : next_tag + 1'b1;
			end
		end
	end
endmodule

/* bench/tb_fetch_cache.sv */
//////////////////////////////////////////////////////////////////////
// self-checking bench, expected blocks come from block_data
//////////////////////////////////////////////////////////////////////
module tb_fetch_cache
	import mem_pkg::*;
	import cache_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// reset, directed tests and 1500 random cycles, with margin
	localparam int MAX_CYCLES = 3000;

	logic                     clock = 1'b0;
	logic                     arst_n;
	fetch_req_t [WAYS-1:0]    fetch_req;
	fetch_rsp_t [WAYS-1:0]    fetch_rsp;
	mem_req_t                 mem_req;
	logic [MEM_TAG_BITS-1:0]  mem_response;
	logic [MEM_TAG_BITS-1:0]  mem_tag;
	logic [MEM_DATA_BITS-1:0] mem_data;
	logic [MEM_ADDR_BITS-1:0] ret_addr;
	int                       refuse_pct;
	int                       seed = 31;
	int                       value_errors = 0;
	int                       other_errors = 0;
	int                       cycles = 0;
	int                       rsp_count = 0;
	// accepted LOADs per block address
	int                       load_count [int];
	logic                     in_flight = 1'b0;
	logic [MEM_TAG_BITS-1:0]  flight_tag;

	always #4 clock = ~clock;

	fetch_cache dut (
		.clock        (clock),
		.arst_n       (arst_n),
		.fetch_req    (fetch_req),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data),
		.fetch_rsp    (fetch_rsp),
		.mem_req      (mem_req)
	);

	mem_model memory (
		.clock        (clock),
		.arst_n       (arst_n),
		.mem_req      (mem_req),
		.refuse_pct   (refuse_pct),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.ret_addr     (ret_addr)
	);

	// memory returns the reference block
	assign mem_data = block_data(ret_addr);

	//////////////////////////////////////////////////////////////////////
	// reference and helpers
	//////////////////////////////////////////////////////////////////////

	// four 16-bit lanes, block address xor a lane constant
	function automatic logic [MEM_DATA_BITS-1:0] block_data(input logic [MEM_ADDR_BITS-1:0] addr);
		logic [MEM_ADDR_BITS-1:0] base;
		base = {addr[MEM_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		return {base ^ 16'hC3A5, base ^ 16'h5A0F, base ^ 16'h9E37, base ^ 16'h1234};
	endfunction

	function automatic int loads_of(input logic [MEM_ADDR_BITS-1:0] addr);
		return load_count.exists(int'(addr)) ? load_count[int'(addr)] : 0;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			value_errors++;
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// hold one way on an address until the cache answers
	task automatic fetch_until_valid(input int way, input logic [MEM_ADDR_BITS-1:0] addr);
		@(negedge clock);
		fetch_req[way].en   = 1'b1;
		fetch_req[way].addr = addr;
		do @(posedge clock); while (!fetch_rsp[way].valid);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking processes
	//////////////////////////////////////////////////////////////////////

	// every valid response carries the block of its address
	always @(posedge clock) begin : compare
		for (int w = 0; w < WAYS; w++) begin
			if (arst_n && fetch_req[w].en && fetch_rsp[w].valid) begin
				rsp_count++;
				check($sformatf("fetch_rsp[%0d].data", w), block_data(fetch_req[w].addr),
					fetch_rsp[w].data);
			end
		end
	end

	// LOAD count per block, one miss in flight, run limit
	always @(posedge clock) begin : watch_bus
		cycles++;
		if (in_flight && mem_tag == flight_tag) begin
			in_flight = 1'b0;
		end
		if (arst_n && mem_req.cmd == LOAD) begin
			if (in_flight) begin
				other_errors++;
				$display("LOAD for %h issued while an accepted block is still in flight",
					mem_req.addr);
			end
			if (mem_response != '0) begin
				load_count[int'(mem_req.addr)] = loads_of(mem_req.addr) + 1;
				in_flight  = 1'b1;
				flight_tag = mem_response;
			end
		end
		if (cycles >= MAX_CYCLES) begin
			other_errors++;
			$display("timeout after %0d cycles, a miss never completed", cycles);
			report_and_finish();
		end
	end

	initial begin : stimulus
		logic [WAYS-1:0] seen;
		int              rsp_before;
		arst_n     = 1'b0;
		fetch_req  = '0;
		refuse_pct = 0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		// nothing enabled, bus quiet
		repeat (4) begin
			@(posedge clock);
			check("fetch_rsp valid", 0, {fetch_rsp[1].valid, fetch_rsp[0].valid});
			check("mem_req.cmd", NONE, mem_req.cmd);
		end
		// cold miss, then a hit on the next cycle
		fetch_until_valid(0, 16'h0128);
		@(posedge clock);
		check("fetch_rsp[0].valid", 1, fetch_rsp[0].valid);
		// two ways, two blocks
		@(negedge clock);
		fetch_req[0] = '{1'b1, 16'h0240};
		fetch_req[1] = '{1'b1, 16'h0A98};
		seen = '0;
		while (seen != '1) begin
			@(posedge clock);
			seen |= {fetch_rsp[1].valid, fetch_rsp[0].valid};
		end
		// mostly refused, still one accepted LOAD
		refuse_pct = 85;
		fetch_until_valid(1, 16'h3310);
		// same index, other tag, each request misses
		refuse_pct = 20;
		repeat (3) begin
			fetch_until_valid(0, 16'h4A28);
			fetch_until_valid(0, 16'h7B28);
		end
		@(negedge clock);
		fetch_req = '0;
		repeat (10) @(negedge clock);
		check("LOADs of 0128", 1, loads_of(16'h0128));
		check("LOADs of 0240", 1, loads_of(16'h0240));
		check("LOADs of 0a98", 1, loads_of(16'h0A98));
		check("LOADs of 3310", 1, loads_of(16'h3310));
		check("LOADs of 4a28", 3, loads_of(16'h4A28));
		check("LOADs of 7b28", 3, loads_of(16'h7B28));
		// random traffic over 64 blocks
		refuse_pct = 25;
		rsp_before = rsp_count;
		repeat (1500) begin
			@(negedge clock);
			for (int w = 0; w < WAYS; w++) begin
				if ({$random(seed)} % 4 == 0) begin
					fetch_req[w].en   = ({$random(seed)} % 8) != 0;
					fetch_req[w].addr = 16'({$random(seed)} % 512);
				end
			end
		end
		@(negedge clock);
		fetch_req = '0;
		// last miss drains
		do @(negedge clock); while (in_flight || mem_req.cmd != NONE);
		check("valid responses in random traffic", 1, rsp_count > rsp_before);
		report_and_finish();
	end
endmodule

/* files.f */
verilog/mem_pkg.sv
verilog/cache_pkg.sv
verilog/cache_mem.sv
verilog/icache_ctrl.sv
verilog/fetch_cache.sv
bench/mem_model.sv
bench/tb_fetch_cache.sv

/* Makefile */
# Verilator build and run of the fetch cache bench
VERILATOR ?= verilator
TOP       ?= tb_fetch_cache
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# result is taken from the log, not from the exit code of the binary
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
